// File: Bender.yml
package:
  name: pzx_sram_port

sources:
  - files:
      - design/pzx_pkg.sv
      - design/sram_if.sv
      - design/pzx_seq.sv
      - design/pzx_addr_counter.sv
      - design/pzx_sram_bank.sv
      - design/pzx_sram_port.sv
  - target: test
    files:
      - dv/tb_pzx_sram_port.sv

// File: design/pzx_addr_counter.sv
`timescale 1ns/100ps
`default_nettype none

module pzx_addr_counter #(
    parameter int ADDR_W = pzx_pkg::ADDR_W_DEFAULT
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              ptr_clear,
    input  wire logic              ptr_inc,
    output logic [ADDR_W-1:0]      addr
);

    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] addr_d;

    // ------------------------------------------------------------
    // Next pointer value
    // ------------------------------------------------------------
    always_comb begin
        addr_d = addr_q;
        if (ptr_clear) begin
            addr_d = '0;
        end else if (ptr_inc) begin
            // Rolls over to zero past the last address
            addr_d = addr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q <= '0;
        end else begin
            addr_q <= addr_d;
        end
    end

    assign addr = addr_q;

endmodule

`default_nettype wire

// File: design/pzx_pkg.sv
`default_nettype none

package pzx_pkg;

    // ------------------------------------------------------------
    // Data and register port widths
    // ------------------------------------------------------------
    parameter int DATA_W = 8;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [7:0]        reg_num_t;

    // Window registers on the host register port
    // Reads and writes both advance the pointer
    parameter reg_num_t SRAM_RDWRINC = 8'hFD;
    // Only writes advance, reads can peek
    parameter reg_num_t SRAM_WRINC   = 8'hFC;

    // ------------------------------------------------------------
    // Memory pointer
    // ------------------------------------------------------------
    // Full tape image needs 21 bits, simulation uses less
    parameter int ADDR_W_DEFAULT = 12;

    // ------------------------------------------------------------
    // Sequencer states, one-hot
    // ------------------------------------------------------------
    typedef enum logic [3:0] {
        IDLE         = 4'b1000,
        READ_ACTIVE  = 4'b0100,
        WRITE_ACTIVE = 4'b0010,
        ADVANCE      = 4'b0001
    } seq_state_t;

endpackage

`default_nettype wire

// File: design/pzx_seq.sv
`timescale 1ns/100ps
`default_nettype none

module pzx_seq (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire pzx_pkg::reg_num_t reg_num,
    input  wire logic              reg_num_changed,
    input  wire logic              reg_rd,
    input  wire logic              reg_wr,
    input  wire pzx_pkg::data_t    din,
    sram_if.ctrl                   mem,
    output logic                   ptr_clear,
    output logic                   ptr_inc
);

    logic                win_sel;
    logic                strobes_low;
    pzx_pkg::seq_state_t state_q;
    pzx_pkg::seq_state_t state_d;

    // ------------------------------------------------------------
    // Port decode
    // ------------------------------------------------------------
    assign win_sel = (reg_num == pzx_pkg::SRAM_RDWRINC) ||
                     (reg_num == pzx_pkg::SRAM_WRINC);

    assign strobes_low = !reg_rd && !reg_wr;

    // Memory strobes follow the host strobes directly
    assign mem.oe_n  = !(win_sel && reg_rd);
    assign mem.we_n  = !(win_sel && reg_wr);
    assign mem.wdata = din;

    // Reselecting a window register rewinds to the start
    assign ptr_clear = reg_num_changed && win_sel;

    // One cycle in ADVANCE moves the pointer on
    assign ptr_inc = (state_q == pzx_pkg::ADVANCE);

    // ------------------------------------------------------------
    // Access tracking FSM
    // ------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            pzx_pkg::IDLE: begin
                if (win_sel && reg_rd) begin
                    state_d = pzx_pkg::READ_ACTIVE;
                end else if (win_sel && reg_wr) begin
                    state_d = pzx_pkg::WRITE_ACTIVE;
                end
            end
            pzx_pkg::READ_ACTIVE: begin
                if (strobes_low) begin
                    // Peek register keeps the pointer where it is
                    if (reg_num == pzx_pkg::SRAM_WRINC) begin
                        state_d = pzx_pkg::IDLE;
                    end else begin
                        state_d = pzx_pkg::ADVANCE;
                    end
                end
            end
            pzx_pkg::WRITE_ACTIVE: begin
                if (strobes_low) begin
                    state_d = pzx_pkg::ADVANCE;
                end
            end
            pzx_pkg::ADVANCE: begin
                state_d = pzx_pkg::IDLE;
            end
            default: begin
                state_d = pzx_pkg::IDLE;
            end
        endcase
    end

    // Clear wins over any access in progress
    always_ff @(posedge clk) begin
        if (!rst_n || ptr_clear) begin
            state_q <= pzx_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// File: design/pzx_sram_bank.sv
`timescale 1ns/100ps
`default_nettype none

module pzx_sram_bank #(
    parameter int ADDR_W = pzx_pkg::ADDR_W_DEFAULT
) (
    input wire logic clk,
    sram_if.mem      mem
);

    localparam int DEPTH = 1 << ADDR_W;

    // Tape image storage, contents undefined at power up
    pzx_pkg::data_t store [DEPTH];

    pzx_pkg::data_t rdata_q;

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------
    // Held strobe rewrites the same byte each cycle
    always_ff @(posedge clk) begin
        if (!mem.we_n) begin
            store[mem.addr] <= mem.wdata;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------
    // Output enable gates the read register
    always_ff @(posedge clk) begin
        if (!mem.oe_n) begin
            rdata_q <= store[mem.addr];
        end
    end

    assign mem.rdata = rdata_q;

endmodule

`default_nettype wire

// File: design/pzx_sram_port.sv
`timescale 1ns/100ps
`default_nettype none

module pzx_sram_port #(
    parameter int ADDR_W = pzx_pkg::ADDR_W_DEFAULT
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    // Host register port
    input  wire pzx_pkg::reg_num_t reg_num,
    input  wire logic              reg_num_changed,
    input  wire logic              reg_rd,
    input  wire logic              reg_wr,
    input  wire pzx_pkg::data_t    din,
    output pzx_pkg::data_t         dout,
    output logic                   oe_n
);

    logic [ADDR_W-1:0] addr;
    logic              ptr_clear;
    logic              ptr_inc;

    sram_if #(.ADDR_W(ADDR_W)) mem_if ();

    // ------------------------------------------------------------
    // Sequencer and pointer
    // ------------------------------------------------------------
    pzx_seq i_pzx_seq (
        .clk             (clk),
        .rst_n           (rst_n),
        .reg_num         (reg_num),
        .reg_num_changed (reg_num_changed),
        .reg_rd          (reg_rd),
        .reg_wr          (reg_wr),
        .din             (din),
        .mem             (mem_if.ctrl),
        .ptr_clear       (ptr_clear),
        .ptr_inc         (ptr_inc)
    );

    pzx_addr_counter #(.ADDR_W(ADDR_W)) i_pzx_addr_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .ptr_clear (ptr_clear),
        .ptr_inc   (ptr_inc),
        .addr      (addr)
    );

    assign mem_if.addr = addr;

    // ------------------------------------------------------------
    // Memory bank
    // ------------------------------------------------------------
    pzx_sram_bank #(.ADDR_W(ADDR_W)) i_pzx_sram_bank (
        .clk (clk),
        .mem (mem_if.mem)
    );

    // Host selects dout while oe_n is low
    assign dout = mem_if.rdata;
    assign oe_n = mem_if.oe_n;

endmodule

`default_nettype wire

// File: design/sram_if.sv
`timescale 1ns/100ps
`default_nettype none

// Memory side of the register window, SRAM style strobes
interface sram_if #(
    parameter int ADDR_W = pzx_pkg::ADDR_W_DEFAULT
);

    logic [ADDR_W-1:0] addr;
    logic              we_n;
    logic              oe_n;
    pzx_pkg::data_t    wdata;
    pzx_pkg::data_t    rdata;

    // Sequencer drives strobes and write data
    modport ctrl (
        output we_n,
        output oe_n,
        output wdata
    );

    // Memory bank sees everything and returns read data
    modport mem (
        input  addr,
        input  we_n,
        input  oe_n,
        input  wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: dv/tb_pzx_sram_port.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pzx_sram_port;

    localparam int ADDR_W       = 6;
    localparam int DEPTH        = 1 << ADDR_W;
    localparam int WAIT_LIMIT   = 20;
    localparam int MIX_OPS      = 400;
    localparam int RUN_LIMIT_NS = 500000;

    logic              clk;
    logic              rst_n;
    pzx_pkg::reg_num_t reg_num;
    logic              reg_num_changed;
    logic              reg_rd;
    logic              reg_wr;
    pzx_pkg::data_t    din;
    pzx_pkg::data_t    dout;
    logic              oe_n;

    integer seed;
    int     data_errors;
    int     strobe_errors;
    int     timeout_errors;

    // Reference image of the tape memory and its pointer
    pzx_pkg::data_t    model_mem [DEPTH];
    logic [ADDR_W-1:0] model_ptr;

    pzx_sram_port #(.ADDR_W(ADDR_W)) i_pzx_sram_port (
        .clk             (clk),
        .rst_n           (rst_n),
        .reg_num         (reg_num),
        .reg_num_changed (reg_num_changed),
        .reg_rd          (reg_rd),
        .reg_wr          (reg_wr),
        .din             (din),
        .dout            (dout),
        .oe_n            (oe_n)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------
    // Helpers and compare tasks
    // ------------------------------------------------------------
    function automatic logic is_window(input pzx_pkg::reg_num_t num);
        return (num == 8'hFD) || (num == 8'hFC);
    endfunction

    function automatic int pick_in_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic finish_run();
        $display("Errors: data %0d, strobe %0d, timeout %0d",
                 data_errors, strobe_errors, timeout_errors);
        if (data_errors + strobe_errors + timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic check_data(input pzx_pkg::data_t got, input pzx_pkg::data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("ERROR dout: got 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp);
        if (got !== exp) begin
            strobe_errors++;
            $display("ERROR oe_n: got 0x%h, expected 0x%h at %0t", got, exp, $time);
        end
    endtask

    // Bounded wait for the read enable to reach a level
    task automatic wait_oe(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (oe_n !== level && cycles < WAIT_LIMIT);
        if (oe_n !== level) begin
            timeout_errors++;
            $display("Timeout: oe_n never went to %0b within %0d cycles", level, WAIT_LIMIT);
            finish_run();
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // ------------------------------------------------------------
    // Host port stimulus, entered on a falling edge
    // ------------------------------------------------------------
    task automatic select_reg(input pzx_pkg::reg_num_t num);
        reg_num         = num;
        reg_num_changed = 1'b1;
        @(negedge clk);
        reg_num_changed = 1'b0;
        if (is_window(num)) begin
            model_ptr = '0;
        end
        @(negedge clk);
    endtask

    // Pointer moves two edges after the strobe falls, so at least two idle cycles
    task automatic read_byte();
        int             len;
        logic           win;
        pzx_pkg::data_t exp;
        len    = pick_in_range(2, 5);
        win    = is_window(reg_num);
        exp    = model_mem[model_ptr];
        reg_rd = 1'b1;
        if (win) begin
            wait_oe(1'b0);
        end
        repeat (len) @(negedge clk);
        check_strobe(oe_n, !win);
        if (win) begin
            check_data(dout, exp);
            // Peek register leaves the pointer alone
            if (reg_num == 8'hFD) begin
                model_ptr++;
            end
        end
        reg_rd = 1'b0;
        idle_cycles(pick_in_range(2, 4));
    endtask

    task automatic write_byte(input pzx_pkg::data_t value);
        int   len;
        logic win;
        len    = pick_in_range(2, 5);
        win    = is_window(reg_num);
        din    = value;
        reg_wr = 1'b1;
        repeat (len) @(negedge clk);
        check_strobe(oe_n, 1'b1);
        reg_wr = 1'b0;
        if (win) begin
            model_mem[model_ptr] = value;
            model_ptr++;
        end
        idle_cycles(pick_in_range(2, 4));
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int i;
        int choice;
        seed            = 32'he326;
        clk             = 1'b0;
        rst_n           = 1'b0;
        reg_num         = 8'h00;
        reg_num_changed = 1'b0;
        reg_rd          = 1'b0;
        reg_wr          = 1'b0;
        din             = 8'h00;
        data_errors     = 0;
        strobe_errors   = 0;
        timeout_errors  = 0;
        model_ptr       = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_strobe(oe_n, 1'b1);

        // Fill the whole image, rewind, read it back in order
        select_reg(8'hFD);
        for (i = 0; i < DEPTH; i++) begin
            write_byte(pzx_pkg::data_t'($random(seed)));
        end
        select_reg(8'hFD);
        for (i = 0; i < DEPTH; i++) begin
            read_byte();
        end

        // Peek window, reads hold and writes advance
        select_reg(8'hFC);
        repeat (3) read_byte();
        write_byte(pzx_pkg::data_t'($random(seed)));
        repeat (2) read_byte();

        // Reselect mid-stream
        select_reg(8'hFD);
        repeat (5) read_byte();
        select_reg(8'hFD);
        read_byte();

        // One byte past the end lands on address 0
        select_reg(8'hFD);
        for (i = 0; i <= DEPTH; i++) begin
            write_byte(pzx_pkg::data_t'($random(seed)));
        end
        select_reg(8'hFD);
        repeat (2) read_byte();

        // Non-window register must not touch the image
        select_reg(8'h3A);
        write_byte(pzx_pkg::data_t'($random(seed)));
        read_byte();
        select_reg(8'hFD);
        for (i = 0; i < DEPTH; i++) begin
            read_byte();
        end

        // Random mix
        for (i = 0; i < MIX_OPS; i++) begin
            choice = pick_in_range(0, 9);
            if (choice == 0) begin
                case (pick_in_range(0, 3))
                    0:       select_reg(8'hFD);
                    1:       select_reg(8'hFC);
                    default: select_reg(pzx_pkg::reg_num_t'($random(seed)));
                endcase
            end else if (choice < 5) begin
                read_byte();
            end else begin
                write_byte(pzx_pkg::data_t'($random(seed)));
            end
        end

        finish_run();
    end

    // Upper bound on the whole run
    initial begin
        #(RUN_LIMIT_NS);
        timeout_errors++;
        $display("Timeout: run did not complete within %0d ns", RUN_LIMIT_NS);
        finish_run();
    end

endmodule

`default_nettype wire

// File: list.f
design/pzx_pkg.sv
design/sram_if.sv
design/pzx_seq.sv
design/pzx_addr_counter.sv
design/pzx_sram_bank.sv
design/pzx_sram_port.sv
dv/tb_pzx_sram_port.sv
